// File: verilog/unpack_pkg.sv
`default_nettype none

package unpack_pkg;

    // Stream geometry
    localparam int PHIT_BITS     = 128;
    localparam int PHIT_BYTES    = PHIT_BITS / 8;
    localparam int HDR_BYTES     = 4;
    localparam int SIMD_LANES    = 4;
    localparam int FLOAT_BITS    = 32;
    localparam int FLOAT_BYTES   = FLOAT_BITS / 8;
    localparam int TAIL_BYTES    = PHIT_BYTES - HDR_BYTES;
    localparam int TAIL_LANES    = TAIL_BYTES / FLOAT_BYTES;

    // Lane buffering and flow control
    localparam int LANE_DEPTH    = 8;
    localparam int LANE_CREDITS  = 4;
    localparam int LANE_PTR_BITS = $clog2(LANE_DEPTH);
    localparam int LANE_CNT_BITS = $clog2(LANE_DEPTH + 1);
    localparam int CREDIT_BITS   = $clog2(LANE_CREDITS + 1);
    localparam int WR_CNT_BITS   = $clog2(SIMD_LANES + 1);

    // Header fields
    localparam int KIND_BITS      = 4;
    localparam int STREAM_ID_BITS = 12;
    localparam int COUNT_BITS     = 16;

    localparam logic [KIND_BITS-1:0] HDR_KIND_DATA = 4'h1;
    localparam logic [KIND_BITS-1:0] HDR_KIND_CFG  = 4'h2;

    // Packet controller states
    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_HEADER  = 2'd1;
    localparam logic [1:0] ST_PAYLOAD = 2'd2;
    localparam logic [1:0] ST_FLUSH   = 2'd3;

    typedef struct packed {
        logic [KIND_BITS-1:0]      kind;
        logic [STREAM_ID_BITS-1:0] stream_id;
        logic [COUNT_BITS-1:0]     word_count;
    } data_hdr_t;

    typedef struct packed {
        logic [KIND_BITS-1:0]                         kind;
        logic [FLOAT_BITS-KIND_BITS-SIMD_LANES-1:0]   reserved;
        logic [SIMD_LANES-1:0]                        lane_enable;
    } cfg_hdr_t;

    // Kind sits in the top nibble of both views
    typedef union packed {
        data_hdr_t data;
        cfg_hdr_t  cfg;
    } hdr_word_u;

    typedef logic [FLOAT_BITS-1:0] lane_word_t;

endpackage

`default_nettype wire

// File: verilog/packet_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module packet_ctrl import unpack_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    input  logic                      in_last,
    input  hdr_word_u                 in_data_low,
    input  logic [SIMD_LANES-1:0]     lane_full,
    output logic                      in_ready,
    output logic                      beat_take,
    output logic                      beat_is_hdr,
    output logic                      flush_take,
    input  logic                      flush_needed,
    output logic [SIMD_LANES-1:0]     lane_enable,
    input  logic [WR_CNT_BITS-1:0]    words_written,
    output logic [STREAM_ID_BITS-1:0] hdr_stream_id,
    output logic                      hdr_strobe,
    output logic                      length_err
);

    logic [1:0]            state;
    logic                  ready_en;
    logic                  drop_pkt;
    logic [COUNT_BITS-1:0] expected;
    logic [COUNT_BITS-1:0] float_count;
    logic [COUNT_BITS-1:0] final_count;
    logic                  any_full;
    logic                  accept;
    logic                  hdr_accept;
    logic                  in_body;
    logic                  is_data;
    logic                  is_cfg;

    assign any_full = |lane_full;
    assign in_ready = ready_en && !any_full && (state != ST_FLUSH);
    assign accept   = in_valid && in_ready;

    assign is_data = (in_data_low.data.kind == HDR_KIND_DATA);
    assign is_cfg  = (in_data_low.cfg.kind == HDR_KIND_CFG);

    // First beat of a packet; a beat that is also last is dropped
    assign hdr_accept  = accept && (state == ST_IDLE) && !in_last;
    assign in_body     = (state == ST_HEADER) || (state == ST_PAYLOAD);
    assign beat_is_hdr = hdr_accept && is_data;
    assign beat_take   = beat_is_hdr || (accept && in_body && !drop_pkt);

    // Tail goes out alone, once the lanes have room
    assign flush_take = (state == ST_FLUSH) && flush_needed && !any_full;

    assign final_count = float_count + COUNT_BITS'(words_written);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            ready_en    <= 1'b0;
            drop_pkt    <= 1'b0;
            lane_enable <= '1;
            hdr_strobe  <= 1'b0;
            length_err  <= 1'b0;
            float_count <= '0;
        end else begin
            ready_en   <= 1'b1;
            hdr_strobe <= beat_is_hdr;
            case (state)
                ST_IDLE: begin
                    if (hdr_accept) begin
                        state       <= ST_HEADER;
                        drop_pkt    <= !is_data;
                        float_count <= '0;
                        if (is_cfg) begin
                            lane_enable <= in_data_low.cfg.lane_enable;
                        end
                    end
                end
                ST_HEADER, ST_PAYLOAD: begin
                    float_count <= final_count;
                    if (accept) begin
                        if (!in_last) begin
                            state <= ST_PAYLOAD;
                        end else if (drop_pkt) begin
                            // Config and unknown packets are not length checked
                            state <= ST_IDLE;
                        end else begin
                            state <= ST_FLUSH;
                        end
                    end
                end
                ST_FLUSH: begin
                    if (flush_take || !flush_needed) begin
                        state <= ST_IDLE;
                        if (final_count != expected) begin
                            length_err <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Data header fields
    always_ff @(posedge clk) begin
        if (beat_is_hdr) begin
            expected      <= in_data_low.data.word_count;
            hdr_stream_id <= in_data_low.data.stream_id;
        end
    end

endmodule

`default_nettype wire

// File: verilog/payload_aligner.sv
`timescale 1ns/100ps
`default_nettype none

module payload_aligner import unpack_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [PHIT_BITS-1:0]        in_data,
    input  logic [PHIT_BYTES-1:0]       in_keep,
    input  logic                        beat_take,
    input  logic                        beat_is_hdr,
    input  logic                        flush_take,
    output lane_word_t [SIMD_LANES-1:0] lane_data,
    output logic [SIMD_LANES-1:0]       lane_keep,
    output logic                        word_strobe,
    output logic                        flush_needed
);

    // Upper bytes of the last accepted beat
    logic [TAIL_BYTES*8-1:0] tail_data;
    logic [TAIL_BYTES-1:0]   tail_keep;
    logic [TAIL_LANES-1:0]   tail_lane_kept;

    // Tail plus the first float of the current beat
    logic [PHIT_BITS-1:0]    join_data;
    logic [PHIT_BYTES-1:0]   join_keep;
    logic [HDR_BYTES-1:0]    head_keep;

    always_ff @(posedge clk) begin
        if (rst) begin
            tail_keep <= '0;
        end else if (beat_take) begin
            tail_keep <= in_keep[PHIT_BYTES-1:HDR_BYTES];
        end else if (flush_take) begin
            tail_keep <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_take) begin
            tail_data <= in_data[PHIT_BITS-1:HDR_BYTES*8];
        end
    end

    // During a flush the input beat is not part of the word
    assign head_keep = flush_take ? '0 : in_keep[HDR_BYTES-1:0];

    assign join_data = {in_data[HDR_BYTES*8-1:0], tail_data};
    assign join_keep = {head_keep, tail_keep};

    assign word_strobe = (beat_take && !beat_is_hdr) || flush_take;

    genvar i;
    generate
        for (i = 0; i < SIMD_LANES; i++) begin : g_lane
            assign lane_data[i] = join_data[i*FLOAT_BITS +: FLOAT_BITS];
            // Only whole floats count
            assign lane_keep[i] = &join_keep[i*FLOAT_BYTES +: FLOAT_BYTES];
        end

        for (i = 0; i < TAIL_LANES; i++) begin : g_tail
            assign tail_lane_kept[i] = &tail_keep[i*FLOAT_BYTES +: FLOAT_BYTES];
        end
    endgenerate

    assign flush_needed = |tail_lane_kept;

endmodule

`default_nettype wire

// File: verilog/lane_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module lane_fifo import unpack_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  lane_word_t wr_data,
    input  logic       wr_en,
    output logic       full,
    output lane_word_t out_data,
    output logic       out_valid,
    input  logic       out_credit
);

    lane_word_t mem [LANE_DEPTH];

    logic [LANE_PTR_BITS-1:0] wr_ptr;
    logic [LANE_PTR_BITS-1:0] rd_ptr;
    logic [LANE_CNT_BITS-1:0] fill;
    logic [CREDIT_BITS-1:0]   credits;
    logic                     push;
    logic                     pop;

    assign full = (fill == LANE_CNT_BITS'(LANE_DEPTH));
    assign push = wr_en && !full;

    // One word per cycle while data and credit are both there
    assign pop = (fill != '0) && (credits != '0);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) begin
                if (wr_ptr == LANE_PTR_BITS'(LANE_DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (pop) begin
                if (rd_ptr == LANE_PTR_BITS'(LANE_DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // Consumer returns a credit for each word it drains
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CREDIT_BITS'(LANE_CREDITS);
        end else begin
            case ({pop, out_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            out_data <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

// File: verilog/float_unpacker_top.sv
`timescale 1ns/100ps
`default_nettype none

module float_unpacker_top import unpack_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [PHIT_BITS-1:0]        in_data,
    input  logic [PHIT_BYTES-1:0]       in_keep,
    input  logic                        in_last,
    input  logic                        in_valid,
    output logic                        in_ready,
    output lane_word_t [SIMD_LANES-1:0] out_data,
    output logic [SIMD_LANES-1:0]       out_valid,
    input  logic [SIMD_LANES-1:0]       out_credit,
    output logic [STREAM_ID_BITS-1:0]   hdr_stream_id,
    output logic                        hdr_strobe,
    output logic                        length_err
);

    logic                        beat_take;
    logic                        beat_is_hdr;
    logic                        flush_take;
    logic                        flush_needed;
    logic                        word_strobe;
    lane_word_t [SIMD_LANES-1:0] lane_data;
    logic [SIMD_LANES-1:0]       lane_keep;
    logic [SIMD_LANES-1:0]       lane_enable;
    logic [SIMD_LANES-1:0]       lane_full;
    logic [SIMD_LANES-1:0]       lane_wr;
    logic [WR_CNT_BITS-1:0]      words_written;

    packet_ctrl i_packet_ctrl (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_last       (in_last),
        .in_data_low   (in_data[HDR_BYTES*8-1:0]),
        .lane_full     (lane_full),
        .in_ready      (in_ready),
        .beat_take     (beat_take),
        .beat_is_hdr   (beat_is_hdr),
        .flush_take    (flush_take),
        .flush_needed  (flush_needed),
        .lane_enable   (lane_enable),
        .words_written (words_written),
        .hdr_stream_id (hdr_stream_id),
        .hdr_strobe    (hdr_strobe),
        .length_err    (length_err)
    );

    payload_aligner i_payload_aligner (
        .clk          (clk),
        .rst          (rst),
        .in_data      (in_data),
        .in_keep      (in_keep),
        .beat_take    (beat_take),
        .beat_is_hdr  (beat_is_hdr),
        .flush_take   (flush_take),
        .lane_data    (lane_data),
        .lane_keep    (lane_keep),
        .word_strobe  (word_strobe),
        .flush_needed (flush_needed)
    );

    genvar i;
    generate
        for (i = 0; i < SIMD_LANES; i++) begin : g_lane
            assign lane_wr[i] = word_strobe && lane_keep[i] && lane_enable[i];

            lane_fifo i_lane_fifo (
                .clk        (clk),
                .rst        (rst),
                .wr_data    (lane_data[i]),
                .wr_en      (lane_wr[i]),
                .full       (lane_full[i]),
                .out_data   (out_data[i]),
                .out_valid  (out_valid[i]),
                .out_credit (out_credit[i])
            );
        end
    endgenerate

    // Floats written this cycle, for the length check
    always_comb begin
        words_written = '0;
        for (int n = 0; n < SIMD_LANES; n++) begin
            words_written = words_written + WR_CNT_BITS'(lane_wr[n]);
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_float_unpacker.sv
`timescale 1ns/100ps
`default_nettype none

module tb_float_unpacker import unpack_pkg::*; ();

    localparam PATTERN_FILE = "bench/unpack_patterns.txt";
    localparam int MAX_WORDS       = 64;
    localparam int CYCLES_PER_BEAT = 40;

    logic                        clk;
    logic                        rst;
    logic [PHIT_BITS-1:0]        in_data;
    logic [PHIT_BYTES-1:0]       in_keep;
    logic                        in_last;
    logic                        in_valid;
    logic                        in_ready;
    lane_word_t [SIMD_LANES-1:0] out_data;
    logic [SIMD_LANES-1:0]       out_valid;
    logic [SIMD_LANES-1:0]       out_credit;
    logic [STREAM_ID_BITS-1:0]   hdr_stream_id;
    logic                        hdr_strobe;
    logic                        length_err;

    // Expected words per lane, consumed in order
    lane_word_t            exp_words [SIMD_LANES][MAX_WORDS];
    int                    exp_head [SIMD_LANES];
    int                    exp_tail [SIMD_LANES];
    logic [FLOAT_BITS-1:0] hdr_q [$];

    int seed;
    int err_count;
    int test_errs;
    int test_count;
    int watch_cycles;

    float_unpacker_top i_float_unpacker_top (
        .clk           (clk),
        .rst           (rst),
        .in_data       (in_data),
        .in_keep       (in_keep),
        .in_last       (in_last),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .out_data      (out_data),
        .out_valid     (out_valid),
        .out_credit    (out_credit),
        .hdr_stream_id (hdr_stream_id),
        .hdr_strobe    (hdr_strobe),
        .length_err    (length_err)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic count_error();
        err_count++;
        test_errs++;
    endtask

    task automatic check_lane_word(input int lane, input lane_word_t got, input lane_word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: lane %0d word %h, expected %h", $time, lane, got, exp);
            count_error();
        end
    endtask

    task automatic check_header(input data_hdr_t got, input data_hdr_t exp);
        if (got.stream_id !== exp.stream_id) begin
            $display("[ERROR] %0t: stream id %h, expected %h", $time, got.stream_id,
                     exp.stream_id);
            count_error();
        end
    endtask

    task automatic check_length_err(input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: length_err %b, expected %b", $time, got, exp);
            count_error();
        end
    endtask

    function automatic int words_pending();
        int n;
        n = hdr_q.size();
        for (int l = 0; l < SIMD_LANES; l++) begin
            n += exp_tail[l] - exp_head[l];
        end
        return n;
    endfunction

    task automatic send_beat(input logic [PHIT_BITS-1:0] data, input logic [PHIT_BYTES-1:0] keep,
                             input logic last, input int idle);
        repeat (idle) begin
            step();
        end
        in_data  = data;
        in_keep  = keep;
        in_last  = last;
        in_valid = 1'b1;
        while (!in_ready) begin
            step();
        end
        // Taken at the coming edge
        step();
        in_valid = 1'b0;
    endtask

    task automatic finish_test(input logic [8*24-1:0] name);
        while (words_pending() != 0) begin
            step();
        end
        repeat (8) begin
            step();
        end
        $display("test %0s finished with %0d errors", name, test_errs);
        test_count++;
        test_errs = 0;
    endtask

    task automatic count_beats(output int beats);
        int               fd;
        int               code;
        logic [8*24-1:0]  tag;
        logic [8*256-1:0] rest;
        beats = -1;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd != 0) begin
            beats = 0;
            code = $fscanf(fd, "%s", tag);
            while (code == 1) begin
                if (tag == "#") begin
                    code = $fgets(rest, fd);
                end else if (tag == "B") begin
                    beats++;
                end
                code = $fscanf(fd, "%s", tag);
            end
            $fclose(fd);
        end
    endtask

    task automatic run_patterns();
        int                    fd;
        int                    code;
        int                    lane;
        int                    last;
        int                    idle;
        int                    flag;
        logic [8*24-1:0]       tag;
        logic [8*24-1:0]       name;
        logic [8*256-1:0]      rest;
        logic [PHIT_BITS-1:0]  b_data;
        logic [PHIT_BYTES-1:0] b_keep;
        logic [FLOAT_BITS-1:0] word;
        logic                  in_test;
        in_test = 1'b0;
        fd = $fopen(PATTERN_FILE, "r");
        code = $fscanf(fd, "%s", tag);
        while (code == 1) begin
            if (tag == "#") begin
                code = $fgets(rest, fd);
            end else if (tag == "T") begin
                if (in_test) begin
                    finish_test(name);
                end
                code = $fscanf(fd, "%s", name);
                in_test = 1'b1;
            end else if (tag == "H") begin
                code = $fscanf(fd, "%h", word);
                hdr_q.push_back(word);
            end else if (tag == "L") begin
                code = $fscanf(fd, "%d %h", lane, word);
                exp_words[lane][exp_tail[lane]] = word;
                exp_tail[lane]++;
            end else if (tag == "B") begin
                code = $fscanf(fd, "%h %h %d %d", b_data, b_keep, last, idle);
                send_beat(b_data, b_keep, last[0], idle);
            end else if (tag == "E") begin
                code = $fscanf(fd, "%d", flag);
                // Ready returns once the flush state is left
                while (!in_ready) begin
                    step();
                end
                check_length_err(length_err, flag[0]);
            end else begin
                $display("Unknown record %0s in the patterns file", tag);
                count_error();
            end
            code = $fscanf(fd, "%s", tag);
        end
        if (in_test) begin
            finish_test(name);
        end
        $fclose(fd);
    endtask

    initial begin
        int beats;
        rst        = 1'b1;
        in_data    = '0;
        in_keep    = '0;
        in_last    = 1'b0;
        in_valid   = 1'b0;
        err_count  = 0;
        test_errs  = 0;
        test_count = 0;
        for (int l = 0; l < SIMD_LANES; l++) begin
            exp_head[l] = 0;
            exp_tail[l] = 0;
        end
        count_beats(beats);
        if (beats < 0) begin
            $display("Could not open the patterns file %0s", PATTERN_FILE);
            $display("TESTBENCH FAILED");
            $finish;
        end else begin
            watch_cycles = beats * CYCLES_PER_BEAT;
            repeat (4) begin
                @(posedge clk);
            end
            #1;
            rst = 1'b0;
            run_patterns();
            $display("%0d tests run, %0d errors", test_count, err_count);
            if (err_count == 0) begin
                $display("TESTBENCH PASSED");
            end else begin
                $display("TESTBENCH FAILED");
            end
            $finish;
        end
    end

    // Output monitor and credit returner
    initial begin
        int        owed [SIMD_LANES];
        int        gap [SIMD_LANES];
        int        pulses [SIMD_LANES];
        int        credits_back [SIMD_LANES];
        data_hdr_t seen_hdr;
        data_hdr_t exp_hdr;
        seed = 18;
        out_credit = '0;
        for (int l = 0; l < SIMD_LANES; l++) begin
            owed[l] = 0;
            gap[l] = 0;
            pulses[l] = 0;
            credits_back[l] = 0;
        end
        forever begin
            step();
            if (hdr_strobe) begin
                seen_hdr = '0;
                seen_hdr.stream_id = hdr_stream_id;
                if (hdr_q.size() == 0) begin
                    $display("Header strobe for stream %h at %0t was not expected",
                             hdr_stream_id, $time);
                    count_error();
                end else begin
                    exp_hdr = hdr_q.pop_front();
                    check_header(seen_hdr, exp_hdr);
                end
            end
            for (int l = 0; l < SIMD_LANES; l++) begin
                if (out_valid[l]) begin
                    pulses[l]++;
                    owed[l]++;
                    // Credits seen by the DUT before this pop
                    if (pulses[l] > credits_back[l] + LANE_CREDITS) begin
                        $display("[ERROR] %0t: lane %0d sent %0d words on %0d credits", $time,
                                 l, pulses[l], credits_back[l] + LANE_CREDITS);
                        count_error();
                    end
                    if (exp_head[l] == exp_tail[l]) begin
                        $display("Lane %0d sent word %h at %0t that no pattern expects", l,
                                 out_data[l], $time);
                        count_error();
                    end else begin
                        check_lane_word(l, out_data[l], exp_words[l][exp_head[l]]);
                        exp_head[l]++;
                    end
                end
                credits_back[l] += out_credit[l];
                out_credit[l] = 1'b0;
                if (owed[l] > 0) begin
                    if (gap[l] == 0) begin
                        out_credit[l] = 1'b1;
                        owed[l]--;
                        gap[l] = $unsigned($random(seed)) % 6;
                    end else begin
                        gap[l]--;
                    end
                end
            end
        end
    end

    initial begin
        wait (watch_cycles > 0);
        repeat (watch_cycles) begin
            @(posedge clk);
        end
        $display("Timeout after %0d cycles, the DUT stopped making progress", watch_cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/unpack_patterns.txt
# T test name, H data header word, L lane and expected word, E length_err after the packet
# B data (128-bit hex, header in the low word), keep (bit n = byte n), last, idle cycles
T split_full
H 10a50007
L 0 3f800000 L 1 40000000 L 2 40400000 L 3 40800000 L 0 40a00000 L 1 40c00000 L 2 40e00000
B 40400000400000003f80000010a50007 ffff 0 0
B 40e0000040c0000040a0000040800000 ffff 1 0
E 0
T partial_keep
H 1b020005
L 0 41100000 L 1 41200000 L 2 41300000 L 3 41400000 L 0 41500000
B 4130000041200000411000001b020005 ffff 0 2
B 41700000416000004150000041400000 03ff 1 0
E 0
T lane_mask
B 00000000000000000000000020000005 ffff 0 0
B 00000000000000000000000000000000 ffff 1 0
E 0
H 1c030004
L 0 42100000 L 2 42300000 L 0 42500000 L 2 42700000
B 4230000042200000421000001c030004 ffff 0 1
B 42700000426000004250000042400000 ffff 1 0
E 0
B 0000000000000000000000002000000f ffff 0 0
B 00000000000000000000000000000000 ffff 1 0
E 0
T single_beat
B 40800000404000004000000011d40003 ffff 1 1
E 0
T credit_bound
H 1e060017
L 0 5e000000 L 0 5e000004 L 0 5e000008 L 0 5e00000c L 0 5e000010 L 0 5e000014
L 1 5e000001 L 1 5e000005 L 1 5e000009 L 1 5e00000d L 1 5e000011 L 1 5e000015
L 2 5e000002 L 2 5e000006 L 2 5e00000a L 2 5e00000e L 2 5e000012 L 2 5e000016
L 3 5e000003 L 3 5e000007 L 3 5e00000b L 3 5e00000f L 3 5e000013
B 5e0000025e0000015e0000001e060017 ffff 0 0
B 5e0000065e0000055e0000045e000003 ffff 0 0
B 5e00000a5e0000095e0000085e000007 ffff 0 0
B 5e00000e5e00000d5e00000c5e00000b ffff 0 0
B 5e0000125e0000115e0000105e00000f ffff 0 0
B 5e0000165e0000155e0000145e000013 ffff 1 0
E 0
T length_err
H 1f070009
L 0 7e000000 L 1 7e000001 L 2 7e000002 L 3 7e000003 L 0 7e000004 L 1 7e000005 L 2 7e000006
B 7e0000027e0000017e0000001f070009 ffff 0 0
B 7e0000067e0000057e0000047e000003 ffff 1 0
E 1

// File: filelist.f
verilog/unpack_pkg.sv
verilog/packet_ctrl.sv
verilog/payload_aligner.sv
verilog/lane_fifo.sv
verilog/float_unpacker_top.sv
bench/tb_float_unpacker.sv

// File: Bender.yml
package:
  name: float_unpacker

sources:
  - verilog/unpack_pkg.sv
  - verilog/packet_ctrl.sv
  - verilog/payload_aligner.sv
  - verilog/lane_fifo.sv
  - verilog/float_unpacker_top.sv
  - target: test
    files:
      - bench/tb_float_unpacker.sv
